//--- design/rv_exec_pkg.sv
package rv_exec_pkg;

    // data path and pc width
    localparam int xlen = 32;

    // register index and file depth
    localparam int reg_addr_w = 5;
    localparam int num_regs = 1 << reg_addr_w;

    // shift amount taken from operand b
    localparam int shamt_w = $clog2(xlen);

    // major opcodes, inst[6:2]
    localparam logic [4:0] opc_op     = 5'b01100;
    localparam logic [4:0] opc_op_imm = 5'b00100;
    localparam logic [4:0] opc_lui    = 5'b01101;
    localparam logic [4:0] opc_auipc  = 5'b00101;
    localparam logic [4:0] opc_jal    = 5'b11011;
    localparam logic [4:0] opc_jalr   = 5'b11001;
    localparam logic [4:0] opc_branch = 5'b11000;

    // branch conditions, inst[14:12]
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // return address step for jal/jalr
    localparam logic [xlen-1:0] link_offset = xlen'(4);

    // alu operations
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_t;

endpackage

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] ra1,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] ra2,
    output logic [rv_exec_pkg::xlen-1:0]       rd1,
    output logic [rv_exec_pkg::xlen-1:0]       rd2,
    input  logic                               we,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] wa,
    input  logic [rv_exec_pkg::xlen-1:0]       wd
);

    logic [rv_exec_pkg::xlen-1:0] regs [rv_exec_pkg::num_regs];

    // writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_exec_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // asynchronous reads, x0 held at zero by reset and the write guard
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

    a_x0_read_zero: assert property (
        @(posedge clk) disable iff (!rst_n) (ra1 == '0) |-> (rd1 == '0)
    );

endmodule

//--- design/operand_stage.sv
`timescale 1ns/10ps

module operand_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               inst_valid,
    input  logic [31:0]                        inst,
    input  logic [rv_exec_pkg::xlen-1:0]       inst_pc,
    input  logic [rv_exec_pkg::xlen-1:0]       rd1,
    input  logic [rv_exec_pkg::xlen-1:0]       rd2,
    output logic [rv_exec_pkg::reg_addr_w-1:0] ra1,
    output logic [rv_exec_pkg::reg_addr_w-1:0] ra2,
    input  logic                               fwd_we,
    input  logic [rv_exec_pkg::reg_addr_w-1:0] fwd_rd,
    input  logic [rv_exec_pkg::xlen-1:0]       fwd_data,
    output logic                               x_valid,
    output logic [31:0]                        x_inst,
    output logic [rv_exec_pkg::xlen-1:0]       x_pc,
    output logic [rv_exec_pkg::xlen-1:0]       x_rs1,
    output logic [rv_exec_pkg::xlen-1:0]       x_rs2
);

    logic                         hit1;
    logic                         hit2;
    logic [rv_exec_pkg::xlen-1:0] op1;
    logic [rv_exec_pkg::xlen-1:0] op2;

    // source indices straight from the incoming word
    assign ra1 = inst[19:15];
    assign ra2 = inst[24:20];

    // the register file is written on the same edge this stage samples,
    // so the instruction in execute has to be bypassed here
    assign hit1 = fwd_we && (fwd_rd == ra1) && (ra1 != '0);
    assign hit2 = fwd_we && (fwd_rd == ra2) && (ra2 != '0);

    assign op1 = hit1 ? fwd_data : rd1;
    assign op2 = hit2 ? fwd_data : rd2;

    // valid strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= inst_valid;
        end
    end

    // instruction, pc and operands
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            x_inst <= inst;
            x_pc   <= inst_pc;
            x_rs1  <= op1;
            x_rs2  <= op2;
        end
    end

    a_valid_after_reset: assert property (
        @(posedge clk) !rst_n |=> !x_valid
    );

endmodule

//--- design/imm_gen.sv
`timescale 1ns/10ps

module imm_gen (
    input  logic [31:0]                  inst,
    output logic [rv_exec_pkg::xlen-1:0] imm
);

    logic [4:0] opcode;
    logic       sign;

    assign opcode = inst[6:2];
    assign sign   = inst[31];

    always_comb begin
        case (opcode)
            // I format
            rv_exec_pkg::opc_op_imm,
            rv_exec_pkg::opc_jalr: begin
                imm = {{(rv_exec_pkg::xlen-12){sign}}, inst[31:20]};
            end
            // B format, bit 0 implied
            rv_exec_pkg::opc_branch: begin
                imm = {{(rv_exec_pkg::xlen-12){sign}}, inst[7], inst[30:25], inst[11:8],
                       1'b0};
            end
            // U format
            rv_exec_pkg::opc_lui,
            rv_exec_pkg::opc_auipc: begin
                imm = {{(rv_exec_pkg::xlen-32){sign}}, inst[31:12], 12'b0};
            end
            // J format
            rv_exec_pkg::opc_jal: begin
                imm = {{(rv_exec_pkg::xlen-20){sign}}, inst[19:12], inst[20], inst[30:21],
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    input  logic [31:0]                  inst,
    input  logic [rv_exec_pkg::xlen-1:0] pc,
    input  logic [rv_exec_pkg::xlen-1:0] rs1,
    input  logic [rv_exec_pkg::xlen-1:0] rs2,
    input  logic [rv_exec_pkg::xlen-1:0] imm,
    output logic [rv_exec_pkg::xlen-1:0] alu_result,
    output logic                         alu_write
);

    logic [4:0]                       opcode;
    logic [2:0]                       funct3;
    logic                             alt;
    rv_exec_pkg::alu_op_t             op;
    logic [rv_exec_pkg::xlen-1:0]     a;
    logic [rv_exec_pkg::xlen-1:0]     b;
    logic [rv_exec_pkg::shamt_w-1:0]  shamt;

    assign opcode = inst[6:2];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // operation select
    always_comb begin
        case (funct3)
            3'b000:  op = (alt && (opcode == rv_exec_pkg::opc_op)) ? rv_exec_pkg::alu_sub
                                                                   : rv_exec_pkg::alu_add;
            3'b001:  op = rv_exec_pkg::alu_sll;
            3'b010:  op = rv_exec_pkg::alu_slt;
            3'b011:  op = rv_exec_pkg::alu_sltu;
            3'b100:  op = rv_exec_pkg::alu_xor;
            3'b101:  op = alt ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
            3'b110:  op = rv_exec_pkg::alu_or;
            default: op = rv_exec_pkg::alu_and;
        endcase
        // upper-immediate classes ignore funct3
        if (opcode == rv_exec_pkg::opc_lui) begin
            op = rv_exec_pkg::alu_pass_b;
        end else if (opcode == rv_exec_pkg::opc_auipc) begin
            op = rv_exec_pkg::alu_add;
        end
    end

    assign a     = (opcode == rv_exec_pkg::opc_auipc) ? pc : rs1;
    assign b     = (opcode == rv_exec_pkg::opc_op) ? rs2 : imm;
    assign shamt = b[rv_exec_pkg::shamt_w-1:0];

    always_comb begin
        case (op)
            rv_exec_pkg::alu_add:    alu_result = a + b;
            rv_exec_pkg::alu_sub:    alu_result = a - b;
            rv_exec_pkg::alu_sll:    alu_result = a << shamt;
            rv_exec_pkg::alu_slt:    alu_result = {{(rv_exec_pkg::xlen-1){1'b0}},
                                                   $signed(a) < $signed(b)};
            rv_exec_pkg::alu_sltu:   alu_result = {{(rv_exec_pkg::xlen-1){1'b0}}, a < b};
            rv_exec_pkg::alu_xor:    alu_result = a ^ b;
            rv_exec_pkg::alu_srl:    alu_result = a >> shamt;
            rv_exec_pkg::alu_sra:    alu_result = $unsigned($signed(a) >>> shamt);
            rv_exec_pkg::alu_or:     alu_result = a | b;
            rv_exec_pkg::alu_and:    alu_result = a & b;
            default:                 alu_result = b;
        endcase
    end

    assign alu_write = (opcode == rv_exec_pkg::opc_op)     ||
                       (opcode == rv_exec_pkg::opc_op_imm) ||
                       (opcode == rv_exec_pkg::opc_lui)    ||
                       (opcode == rv_exec_pkg::opc_auipc);

endmodule

//--- design/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  logic [31:0]                  inst,
    input  logic [rv_exec_pkg::xlen-1:0] pc,
    input  logic [rv_exec_pkg::xlen-1:0] rs1,
    input  logic [rv_exec_pkg::xlen-1:0] rs2,
    input  logic [rv_exec_pkg::xlen-1:0] imm,
    output logic                         take,
    output logic [rv_exec_pkg::xlen-1:0] target,
    output logic                         link,
    output logic [rv_exec_pkg::xlen-1:0] link_data
);

    logic [4:0]                   opcode;
    logic                         is_jal;
    logic                         is_jalr;
    logic                         is_branch;
    logic                         eq;
    logic                         lt;
    logic                         ltu;
    logic                         cond;
    logic [rv_exec_pkg::xlen-1:0] jalr_sum;

    assign opcode    = inst[6:2];
    assign is_jal    = (opcode == rv_exec_pkg::opc_jal);
    assign is_jalr   = (opcode == rv_exec_pkg::opc_jalr);
    assign is_branch = (opcode == rv_exec_pkg::opc_branch);

    // comparator
    assign eq  = (rs1 == rs2);
    assign lt  = ($signed(rs1) < $signed(rs2));
    assign ltu = (rs1 < rs2);

    always_comb begin
        case (inst[14:12])
            rv_exec_pkg::f3_beq:  cond = eq;
            rv_exec_pkg::f3_bne:  cond = !eq;
            rv_exec_pkg::f3_blt:  cond = lt;
            rv_exec_pkg::f3_bge:  cond = !lt;
            rv_exec_pkg::f3_bltu: cond = ltu;
            rv_exec_pkg::f3_bgeu: cond = !ltu;
            default:              cond = 1'b0;
        endcase
    end

    assign take = is_jal || is_jalr || (is_branch && cond);

    // jalr drops the low bit of the computed address
    assign jalr_sum = rs1 + imm;
    assign target   = is_jalr ? {jalr_sum[rv_exec_pkg::xlen-1:1], 1'b0} : pc + imm;

    assign link      = is_jal || is_jalr;
    assign link_data = pc + rv_exec_pkg::link_offset;

endmodule

//--- design/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               x_valid,
    input  logic [31:0]                        x_inst,
    input  logic [rv_exec_pkg::xlen-1:0]       x_pc,
    input  logic [rv_exec_pkg::xlen-1:0]       x_rs1,
    input  logic [rv_exec_pkg::xlen-1:0]       x_rs2,
    output logic                               fwd_we,
    output logic [rv_exec_pkg::reg_addr_w-1:0] fwd_rd,
    output logic [rv_exec_pkg::xlen-1:0]       fwd_data,
    output logic                               retire_valid,
    output logic                               wb_we,
    output logic [rv_exec_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_exec_pkg::xlen-1:0]       wb_data,
    output logic                               redirect,
    output logic [rv_exec_pkg::xlen-1:0]       redirect_pc
);

    logic [rv_exec_pkg::xlen-1:0] imm;
    logic [rv_exec_pkg::xlen-1:0] alu_result;
    logic                         alu_write;
    logic                         take;
    logic [rv_exec_pkg::xlen-1:0] target;
    logic                         link;
    logic [rv_exec_pkg::xlen-1:0] link_data;

    imm_gen u_imm_gen (
        .inst (x_inst),
        .imm  (imm)
    );

    alu_unit u_alu_unit (
        .inst       (x_inst),
        .pc         (x_pc),
        .rs1        (x_rs1),
        .rs2        (x_rs2),
        .imm        (imm),
        .alu_result (alu_result),
        .alu_write  (alu_write)
    );

    branch_unit u_branch_unit (
        .inst      (x_inst),
        .pc        (x_pc),
        .rs1       (x_rs1),
        .rs2       (x_rs2),
        .imm       (imm),
        .take      (take),
        .target    (target),
        .link      (link),
        .link_data (link_data)
    );

    // write request of the instruction in execute, also the bypass source
    assign fwd_rd   = x_inst[11:7];
    assign fwd_we   = x_valid && (alu_write || link) && (fwd_rd != '0);
    assign fwd_data = link ? link_data : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            wb_we        <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            retire_valid <= x_valid;
            wb_we        <= fwd_we;
            redirect     <= x_valid && take;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd       <= fwd_rd;
        wb_data     <= fwd_data;
        redirect_pc <= target;
    end

    // targets stay halfword aligned through the whole core
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) redirect |-> !redirect_pc[0]
    );

endmodule

//--- design/exec_core.sv
`timescale 1ns/10ps

module exec_core (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               inst_valid,
    input  logic [31:0]                        inst,
    input  logic [rv_exec_pkg::xlen-1:0]       inst_pc,
    output logic                               retire_valid,
    output logic                               wb_we,
    output logic [rv_exec_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_exec_pkg::xlen-1:0]       wb_data,
    output logic                               redirect,
    output logic [rv_exec_pkg::xlen-1:0]       redirect_pc
);

    logic [rv_exec_pkg::reg_addr_w-1:0] ra1;
    logic [rv_exec_pkg::reg_addr_w-1:0] ra2;
    logic [rv_exec_pkg::xlen-1:0]       rd1;
    logic [rv_exec_pkg::xlen-1:0]       rd2;
    logic                               fwd_we;
    logic [rv_exec_pkg::reg_addr_w-1:0] fwd_rd;
    logic [rv_exec_pkg::xlen-1:0]       fwd_data;
    logic                               x_valid;
    logic [31:0]                        x_inst;
    logic [rv_exec_pkg::xlen-1:0]       x_pc;
    logic [rv_exec_pkg::xlen-1:0]       x_rs1;
    logic [rv_exec_pkg::xlen-1:0]       x_rs2;

    operand_stage u_operand_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .rd1        (rd1),
        .rd2        (rd2),
        .ra1        (ra1),
        .ra2        (ra2),
        .fwd_we     (fwd_we),
        .fwd_rd     (fwd_rd),
        .fwd_data   (fwd_data),
        .x_valid    (x_valid),
        .x_inst     (x_inst),
        .x_pc       (x_pc),
        .x_rs1      (x_rs1),
        .x_rs2      (x_rs2)
    );

    exec_stage u_exec_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .x_valid      (x_valid),
        .x_inst       (x_inst),
        .x_pc         (x_pc),
        .x_rs1        (x_rs1),
        .x_rs2        (x_rs2),
        .fwd_we       (fwd_we),
        .fwd_rd       (fwd_rd),
        .fwd_data     (fwd_data),
        .retire_valid (retire_valid),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    // written by the instruction in execute
    reg_file u_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (fwd_we),
        .wa    (fwd_rd),
        .wd    (fwd_data)
    );

endmodule

//--- tests/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// one expected retire
typedef struct packed {
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        redirect;
    logic [31:0] target;
} retire_rec_t;

// architectural state, x0 stays zero
logic [31:0] model_regs [32];

function automatic logic [31:0] imm_of(input logic [31:0] w);
    case (w[6:2])
        rv_exec_pkg::opc_op_imm,
        rv_exec_pkg::opc_jalr:   return {{20{w[31]}}, w[31:20]};
        rv_exec_pkg::opc_branch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        rv_exec_pkg::opc_lui,
        rv_exec_pkg::opc_auipc:  return {w[31:12], 12'h000};
        rv_exec_pkg::opc_jal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:                 return 32'h0;
    endcase
endfunction

// funct7 bit 30 only turns add into sub for register-register ops
function automatic rv_exec_pkg::alu_op_t alu_op_of(input logic [31:0] w);
    case (w[14:12])
        3'b000:  return (w[30] && w[6:2] == rv_exec_pkg::opc_op) ? rv_exec_pkg::alu_sub
                                                                  : rv_exec_pkg::alu_add;
        3'b001:  return rv_exec_pkg::alu_sll;
        3'b010:  return rv_exec_pkg::alu_slt;
        3'b011:  return rv_exec_pkg::alu_sltu;
        3'b100:  return rv_exec_pkg::alu_xor;
        3'b101:  return w[30] ? rv_exec_pkg::alu_sra : rv_exec_pkg::alu_srl;
        3'b110:  return rv_exec_pkg::alu_or;
        default: return rv_exec_pkg::alu_and;
    endcase
endfunction

function automatic logic [31:0] alu_apply(input rv_exec_pkg::alu_op_t op,
                                          input logic [31:0] a, input logic [31:0] b);
    case (op)
        rv_exec_pkg::alu_add:  return a + b;
        rv_exec_pkg::alu_sub:  return a - b;
        rv_exec_pkg::alu_sll:  return a << b[4:0];
        rv_exec_pkg::alu_slt:  return {31'b0, $signed(a) < $signed(b)};
        rv_exec_pkg::alu_sltu: return {31'b0, a < b};
        rv_exec_pkg::alu_xor:  return a ^ b;
        rv_exec_pkg::alu_srl:  return a >> b[4:0];
        rv_exec_pkg::alu_sra:  return $signed(a) >>> b[4:0];
        rv_exec_pkg::alu_or:   return a | b;
        default:               return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        rv_exec_pkg::f3_beq:  return a == b;
        rv_exec_pkg::f3_bne:  return a != b;
        rv_exec_pkg::f3_blt:  return $signed(a) < $signed(b);
        rv_exec_pkg::f3_bge:  return $signed(a) >= $signed(b);
        rv_exec_pkg::f3_bltu: return a < b;
        rv_exec_pkg::f3_bgeu: return a >= b;
        default:              return 1'b0;
    endcase
endfunction

// executes one instruction in issue order and updates the state
function automatic retire_rec_t model_execute(input logic [31:0] w, input logic [31:0] pc);
    retire_rec_t r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] sum;
    r   = '0;
    a   = model_regs[w[19:15]];
    b   = model_regs[w[24:20]];
    imm = imm_of(w);
    sum = a + imm;
    r.rd = w[11:7];
    case (w[6:2])
        rv_exec_pkg::opc_op: begin
            r.we   = 1'b1;
            r.data = alu_apply(alu_op_of(w), a, b);
        end
        rv_exec_pkg::opc_op_imm: begin
            r.we   = 1'b1;
            r.data = alu_apply(alu_op_of(w), a, imm);
        end
        rv_exec_pkg::opc_lui: begin
            r.we   = 1'b1;
            r.data = imm;
        end
        rv_exec_pkg::opc_auipc: begin
            r.we   = 1'b1;
            r.data = pc + imm;
        end
        rv_exec_pkg::opc_jal, rv_exec_pkg::opc_jalr: begin
            r.we       = 1'b1;
            r.data     = pc + 32'd4;
            r.redirect = 1'b1;
            r.target   = (w[6:2] == rv_exec_pkg::opc_jal) ? pc + imm : {sum[31:1], 1'b0};
        end
        rv_exec_pkg::opc_branch: begin
            r.redirect = branch_taken(w[14:12], a, b);
            r.target   = pc + imm;
        end
        default: begin
        end
    endcase
    if (r.rd == 5'd0) begin
        r.we = 1'b0;
    end
    if (r.we) begin
        model_regs[r.rd] = r.data;
    end
    return r;
endfunction

`endif

//--- tests/tb_exec_core.sv
`timescale 1ns/10ps

module tb_exec_core;

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        retire_valid;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    int unsigned cyc = 0;
    int unsigned errors = 0;
    int unsigned passed = 0;
    int unsigned failed = 0;
    logic [31:0] next_pc;

    `include "exec_model.svh"

    retire_rec_t exp_q [$];
    int unsigned due_q [$];

    exec_core DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .retire_valid (retire_valid),
        .wb_we        (wb_we),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // instruction encoders
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [4:0] opc);
        return {f7, rs2, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] opc);
        return {imm, rs1, f3, rd, opc, 2'b11};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
                rv_exec_pkg::opc_branch, 2'b11};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::opc_jal, 2'b11};
    endfunction

    // random OP or OP-IMM, plus LUI and AUIPC when allowed
    function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [4:0] rs2, input bit allow_upper);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int unsigned pick;
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom);
        f7   = 7'h00;
        pick = allow_upper ? $urandom_range(0, 3) : $urandom_range(0, 1);
        if ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) begin
            f7 = 7'h20;
        end
        // shift immediates carry only the shift kind above shamt
        if (f3 == 3'b001 || f3 == 3'b101) begin
            imm[11:5] = f7;
        end
        case (pick)
            0:       return r_word(f7, rs2, rs1, f3, rd, rv_exec_pkg::opc_op);
            1:       return i_word(imm, rs1, f3, rd, rv_exec_pkg::opc_op_imm);
            2:       return {20'($urandom), rd, rv_exec_pkg::opc_lui, 2'b11};
            default: return {20'($urandom), rd, rv_exec_pkg::opc_auipc, 2'b11};
        endcase
    endfunction

    task automatic issue(input logic [31:0] word);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
        inst_pc    <= next_pc;
        exp_q.push_back(model_execute(word, next_pc));
        // sampled on the next edge, outputs visible after the one after
        due_q.push_back(cyc + 3);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic gap();
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    task automatic drain();
        int unsigned waited;
        gap();
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout: %0d instructions never retired", exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH %s: got %h expected %h", sig, got, want);
        errors++;
    endtask

    task automatic check_retire(input retire_rec_t e, input int unsigned due);
        assert (cyc == due) else begin
            $display("instruction retired at cycle %0d instead of cycle %0d", cyc, due);
            errors++;
        end
        assert (wb_we == e.we) else report_mismatch("wb_we", 32'(wb_we), 32'(e.we));
        if (e.we) begin
            assert (wb_rd == e.rd) else report_mismatch("wb_rd", 32'(wb_rd), 32'(e.rd));
            assert (wb_data == e.data) else report_mismatch("wb_data", wb_data, e.data);
        end
        assert (redirect == e.redirect) else
            report_mismatch("redirect", 32'(redirect), 32'(e.redirect));
        if (e.redirect) begin
            assert (redirect_pc == e.target) else
                report_mismatch("redirect_pc", redirect_pc, e.target);
        end
    endtask

    always @(negedge clk) begin : retire_check
        retire_rec_t exp_rec;
        int unsigned due;
        if (rst_n && retire_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("retire at cycle %0d with nothing outstanding", cyc);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_rec = exp_q.pop_front();
                due     = due_q.pop_front();
                check_retire(exp_rec, due);
            end
        end
    end

    task automatic report_test(input string name, input int unsigned errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
            passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
            failed++;
        end
    endtask

    // addi rN, rN, 0 shows every register on wb_data
    task automatic compare_all_regs();
        for (int r = 1; r < 32; r++) begin
            issue(i_word(12'h000, 5'(r), 3'b000, 5'(r), rv_exec_pkg::opc_op_imm));
        end
        drain();
    endtask

    initial begin
        int unsigned e0;
        logic [4:0]  prev_rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [4:0]  opc;
        logic [31:0] w;
        logic [2:0]  conds [6];
        void'($urandom(32'h0ae17a45));
        conds = '{rv_exec_pkg::f3_beq, rv_exec_pkg::f3_bne, rv_exec_pkg::f3_blt,
                  rv_exec_pkg::f3_bge, rv_exec_pkg::f3_bltu, rv_exec_pkg::f3_bgeu};
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = 32'h0;
        inst_pc    = 32'h0;
        next_pc    = 32'h0000_1000;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // outputs quiet until the first strobe
        e0 = errors;
        repeat (4) begin
            @(negedge clk);
            assert (!retire_valid && !wb_we && !redirect) else begin
                $display("retire outputs active after reset with no instruction");
                errors++;
            end
        end
        report_test("reset", e0);

        e0 = errors;
        for (int i = 0; i < 120; i++) begin
            issue(alu_word(5'($urandom), 5'($urandom), 5'($urandom), 1'b1));
            if ($urandom_range(0, 3) == 0) begin
                gap();
            end
        end
        drain();
        report_test("arithmetic", e0);

        // each instruction reads the previous destination
        e0 = errors;
        prev_rd = 5'd1;
        for (int i = 0; i < 80; i++) begin
            rs2 = ($urandom_range(0, 1) == 1) ? prev_rd : 5'($urandom);
            rd  = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom);
            issue(alu_word(rd, prev_rd, rs2, 1'b0));
            prev_rd = rd;
        end
        drain();
        report_test("forwarding", e0);

        e0 = errors;
        for (int c = 0; c < 6; c++) begin
            for (int i = 0; i < 16; i++) begin
                rs1 = 5'($urandom);
                rs2 = ($urandom_range(0, 3) == 0) ? rs1 : 5'($urandom);
                issue(b_word({12'($urandom), 1'b0}, rs2, rs1, conds[c]));
            end
        end
        drain();
        report_test("branches", e0);

        e0 = errors;
        for (int i = 0; i < 40; i++) begin
            rd = 5'($urandom);
            if ($urandom_range(0, 1) == 1) begin
                issue(j_word({20'($urandom), 1'b0}, rd));
            end else begin
                w = i_word(12'($urandom), 5'($urandom), 3'b000, rd, rv_exec_pkg::opc_jalr);
                issue(w);
            end
        end
        drain();
        report_test("jumps", e0);

        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            opc = 5'($urandom);
            if (opc inside {rv_exec_pkg::opc_op, rv_exec_pkg::opc_op_imm,
                            rv_exec_pkg::opc_lui, rv_exec_pkg::opc_auipc,
                            rv_exec_pkg::opc_jal, rv_exec_pkg::opc_jalr,
                            rv_exec_pkg::opc_branch}) begin
                opc = 5'b00000;
            end
            w      = $urandom;
            w[6:0] = {opc, 2'b11};
            issue(w);
        end
        drain();
        compare_all_regs();
        report_test("unsupported", e0);

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+tests
design/rv_exec_pkg.sv
design/reg_file.sv
design/operand_stage.sv
design/imm_gen.sv
design/alu_unit.sv
design/branch_unit.sv
design/exec_stage.sv
design/exec_core.sv
tests/tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_exec_core \
    -Mdir obj_dir -o sim_exec_core
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_exec_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0
